// ==== logic/apbLayerRegs.sv ====
`default_nettype none

module apbLayerRegs #(
	parameter int NUM_LAYERS = 4
)(
	input	logic					clk,
	input	logic					rstN,
	input	apbPkg::apbReqT			apbReq,
	output	apbPkg::apbRspT			apbRsp,
	output	screenPkg::layerCfgT	cfg [NUM_LAYERS]
);

import screenPkg::*;
import apbPkg::*;

localparam logic [3:0] LAST_DIGIT = 4'd9;

logic			access;
logic	[7:0]	layerIdx;
logic	[7:0]	regOff;
logic			isCtrl;
logic			isPos;
logic			addrBad;
logic			digitBad;
logic			accessErr;
logic	[31:0]	rdWord;

always_comb begin
	access = apbReq.psel && apbReq.penable;
	layerIdx = apbReq.paddr / LAYER_STRIDE;
	regOff = apbReq.paddr % LAYER_STRIDE;
	isCtrl = (regOff == CTRL_OFFSET);
	isPos = (regOff == POS_OFFSET);
	// beyond the last layer or not on a register boundary
	addrBad = (layerIdx >= NUM_LAYERS) || !(isCtrl || isPos);
	digitBad = apbReq.pwrite && isCtrl
		&& (apbReq.pwdata[CTRL_DIGIT_LSB +: 4] > LAST_DIGIT);
	accessErr = addrBad || digitBad;
end

always_comb begin
	rdWord = '0;
	for (int k = 0; k < NUM_LAYERS; k++) begin
		if (layerIdx == k) begin
			if (isCtrl) begin
				rdWord[CTRL_ENABLE_BIT] = cfg[k].enable;
				rdWord[CTRL_DIGIT_LSB +: 4] = cfg[k].digit;
				rdWord[CTRL_COLOUR_LSB +: $bits(rgbT)] = cfg[k].colour;
			end else if (isPos) begin
				rdWord[POS_X_LSB +: $bits(coordT)] = cfg[k].topLeftX;
				rdWord[POS_Y_LSB +: $bits(coordT)] = cfg[k].topLeftY;
			end
		end
	end
end

// no wait states, response in the access cycle
always_comb begin
	apbRsp.pready = access;
	apbRsp.pslverr = access && accessErr;
	apbRsp.prdata = (access && !apbReq.pwrite) ? rdWord : '0;
end

always_ff @(posedge clk) begin
	if (!rstN) begin
		for (int k = 0; k < NUM_LAYERS; k++) begin
			cfg[k] <= '0;
		end
	end else if (access && apbReq.pwrite && !accessErr) begin
		for (int k = 0; k < NUM_LAYERS; k++) begin
			if (layerIdx == k) begin
				if (isCtrl) begin
					cfg[k].enable <= apbReq.pwdata[CTRL_ENABLE_BIT];
					cfg[k].digit <= apbReq.pwdata[CTRL_DIGIT_LSB +: 4];
					cfg[k].colour <= rgbT'(apbReq.pwdata[CTRL_COLOUR_LSB +: $bits(rgbT)]);
				end else begin
					cfg[k].topLeftX <= apbReq.pwdata[POS_X_LSB +: $bits(coordT)];
					cfg[k].topLeftY <= apbReq.pwdata[POS_Y_LSB +: $bits(coordT)];
				end
			end
		end
	end
end

// every access cycle follows a setup cycle
assert property (@(posedge clk) disable iff (!rstN)
	apbReq.penable |-> apbReq.psel && $past(apbReq.psel && !apbReq.penable))
	else $error("APB access without a preceding setup cycle");

endmodule

`default_nettype wire

// ==== logic/apbPkg.sv ====
`default_nettype none

package apbPkg;

typedef struct packed {
	logic			psel;
	logic			penable;
	logic			pwrite;
	logic	[7:0]	paddr;
	logic	[31:0]	pwdata;
} apbReqT;

typedef struct packed {
	logic			pready;
	logic			pslverr;
	logic	[31:0]	prdata;
} apbRspT;

// per-layer register window
localparam logic [7:0] CTRL_OFFSET = 8'd0;
localparam logic [7:0] POS_OFFSET = 8'd4;
localparam logic [7:0] LAYER_STRIDE = 8'd8;

// control register fields
localparam int unsigned CTRL_ENABLE_BIT = 31;
localparam int unsigned CTRL_DIGIT_LSB = 16;
localparam int unsigned CTRL_COLOUR_LSB = 0;

// position register fields
localparam int unsigned POS_X_LSB = 16;
localparam int unsigned POS_Y_LSB = 0;

endpackage

`default_nettype wire

// ==== logic/digitLayer.sv ====
`default_nettype none

module digitLayer(
	input	logic					clk,
	input	logic					rstN,
	input	screenPkg::scanPixelT	scan,
	input	screenPkg::layerCfgT	cfg,
	output	screenPkg::layerOutT	layerOut
);

import screenPkg::*;

localparam int unsigned IDX_BITS = $clog2(GLYPH_SIZE);

coordT						offsetX;
coordT						offsetY;
logic						insideRectangle;
logic	[IDX_BITS-1:0]		col;
logic	[IDX_BITS-1:0]		row;
logic	[GLYPH_SIZE-1:0]	rowBits;
logic						fontBit;

// rectangle hit test
always_comb begin
	offsetX = scan.x - cfg.topLeftX;
	offsetY = scan.y - cfg.topLeftY;
	insideRectangle = (scan.x >= cfg.topLeftX) && (scan.y >= cfg.topLeftY)
		&& (offsetX < GLYPH_SIZE) && (offsetY < GLYPH_SIZE);
end

// font lookup
always_comb begin
	col = offsetX[IDX_BITS-1:0];
	row = offsetY[IDX_BITS-1:0];
	rowBits = glyphRow(cfg.digit, row);
	fontBit = rowBits[(GLYPH_SIZE - 1) - col];
end

always_ff @(posedge clk) begin
	layerOut.x <= scan.x;
	layerOut.y <= scan.y;
	layerOut.colour <= cfg.colour;
	if (!rstN) begin
		layerOut.valid <= 1'b0;
		layerOut.frameStart <= 1'b0;
		layerOut.draw <= 1'b0;
	end else begin
		layerOut.valid <= scan.valid;
		layerOut.frameStart <= scan.frameStart;
		layerOut.draw <= scan.valid && cfg.enable && insideRectangle && fontBit;
	end
end

endmodule

`default_nettype wire

// ==== logic/layerMixer.sv ====
`default_nettype none

module layerMixer #(
	parameter int NUM_LAYERS = 4
)(
	input	logic					clk,
	input	logic					rstN,
	input	screenPkg::layerOutT	layers [NUM_LAYERS],
	output	screenPkg::layerOutT	pixelOut
);

import screenPkg::*;

logic	anyDraw;
rgbT	winColour;

always_comb begin
	anyDraw = 1'b0;
	winColour = '0;
	// walk downwards so the lowest index lands last
	for (int k = NUM_LAYERS - 1; k >= 0; k--) begin
		if (layers[k].draw) begin
			anyDraw = 1'b1;
			winColour = layers[k].colour;
		end
	end
end

always_ff @(posedge clk) begin
	pixelOut.x <= layers[0].x;
	pixelOut.y <= layers[0].y;
	pixelOut.colour <= winColour;
	if (!rstN) begin
		pixelOut.valid <= 1'b0;
		pixelOut.frameStart <= 1'b0;
		pixelOut.draw <= 1'b0;
	end else begin
		pixelOut.valid <= layers[0].valid;
		pixelOut.frameStart <= layers[0].frameStart;
		pixelOut.draw <= anyDraw;
	end
end

assert property (@(posedge clk) disable iff (!rstN)
	pixelOut.draw |-> pixelOut.valid)
	else $error("pixel drawn outside a valid cycle");

// layer 0 coordinates stand for every layer
for (genvar k = 1; k < NUM_LAYERS; k++) begin : alignedCheck
	assert property (@(posedge clk) disable iff (!rstN)
		layers[k].valid |-> (layers[k].x == layers[0].x) && (layers[k].y == layers[0].y))
		else $error("layer %0d out of step with layer 0", k);
end

endmodule

`default_nettype wire

// ==== logic/luckScreen.sv ====
`default_nettype none

module luckScreen #(
	parameter int NUM_LAYERS = 4,
	parameter int H_ACTIVE = 32,
	parameter int V_ACTIVE = 24
)(
	input	logic					clk,
	input	logic					rstN,
	input	apbPkg::apbReqT			apbReq,
	output	apbPkg::apbRspT			apbRsp,
	output	screenPkg::layerOutT	pixelOut
);

import screenPkg::*;

scanPixelT	scan;
layerCfgT	cfg [NUM_LAYERS];
layerOutT	layerOuts [NUM_LAYERS];

rasterScanner #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) rasterScanner_i(
// input
	.clk(clk),
	.rstN(rstN),
// output
	.scan(scan)
);

apbLayerRegs #(.NUM_LAYERS(NUM_LAYERS)) apbLayerRegs_i(
// input
	.clk(clk),
	.rstN(rstN),
	.apbReq(apbReq),
// output
	.apbRsp(apbRsp),
	.cfg(cfg)
);

// one glyph per layer
for (genvar k = 0; k < NUM_LAYERS; k++) begin : layerGen
	digitLayer digitLayer_i(
	// input
		.clk(clk),
		.rstN(rstN),
		.scan(scan),
		.cfg(cfg[k]),
	// output
		.layerOut(layerOuts[k])
	);
end

layerMixer #(.NUM_LAYERS(NUM_LAYERS)) layerMixer_i(
// input
	.clk(clk),
	.rstN(rstN),
	.layers(layerOuts),
// output
	.pixelOut(pixelOut)
);

endmodule

`default_nettype wire

// ==== logic/rasterScanner.sv ====
`default_nettype none

module rasterScanner #(
	parameter int H_ACTIVE = 32,
	parameter int V_ACTIVE = 24
)(
	input	logic					clk,
	input	logic					rstN,
	output	screenPkg::scanPixelT	scan
);

import screenPkg::*;

localparam coordT X_LAST = coordT'(H_ACTIVE - 1);
localparam coordT Y_LAST = coordT'(V_ACTIVE - 1);

coordT xCnt;
coordT yCnt;

always_ff @(posedge clk) begin
	if (!rstN) begin
		xCnt <= '0;
		yCnt <= '0;
	end else if (xCnt == X_LAST) begin
		xCnt <= '0;
		yCnt <= (yCnt == Y_LAST) ? '0 : yCnt + 1'b1;
	end else begin
		xCnt <= xCnt + 1'b1;
	end
end

// output stage
always_ff @(posedge clk) begin
	scan.x <= xCnt;
	scan.y <= yCnt;
	if (!rstN) begin
		scan.valid <= 1'b0;
		scan.frameStart <= 1'b0;
	end else begin
		scan.valid <= 1'b1;
		scan.frameStart <= (xCnt == '0) && (yCnt == '0);
	end
end

assert property (@(posedge clk) disable iff (!rstN)
	scan.valid |-> (scan.x < H_ACTIVE) && (scan.y < V_ACTIVE))
	else $error("scan coordinate outside the active area");

endmodule

`default_nettype wire

// ==== logic/screenPkg.sv ====
`default_nettype none

package screenPkg;

typedef logic [10:0] coordT;

localparam int unsigned GLYPH_SIZE = 8;

// 3 red, 3 green, 2 blue
typedef struct packed {
	logic	[2:0]	red;
	logic	[2:0]	green;
	logic	[1:0]	blue;
} rgbT;

typedef struct packed {
	logic	valid;
	logic	frameStart;
	coordT	x;
	coordT	y;
} scanPixelT;

typedef struct packed {
	logic	valid;
	logic	frameStart;
	coordT	x;
	coordT	y;
	logic	draw;
	rgbT	colour;
} layerOutT;

typedef struct packed {
	logic			enable;
	logic	[3:0]	digit;
	rgbT			colour;
	coordT			topLeftX;
	coordT			topLeftY;
} layerCfgT;

// seven-segment font, bit 7 is the leftmost column
function automatic logic [7:0] glyphRow(input logic [3:0] digit, input logic [2:0] row);
	logic [6:0] seg;
	logic [7:0] rowBits;
	// segments in order a b c d e f g
	case (digit)
		4'd0: seg = 7'b1111110;
		4'd1: seg = 7'b0110000;
		4'd2: seg = 7'b1101101;
		4'd3: seg = 7'b1111001;
		4'd4: seg = 7'b0110011;
		4'd5: seg = 7'b1011011;
		4'd6: seg = 7'b1011111;
		4'd7: seg = 7'b1110000;
		4'd8: seg = 7'b1111111;
		4'd9: seg = 7'b1111011;
		default: seg = 7'b0000000;
	endcase
	case (row)
		3'd0: rowBits = seg[6] ? 8'b0111_1100 : 8'b0;
		3'd1, 3'd2: rowBits = (seg[1] ? 8'b0100_0000 : 8'b0) | (seg[5] ? 8'b0000_0100 : 8'b0);
		3'd3: rowBits = seg[0] ? 8'b0111_1100 : 8'b0;
		3'd4, 3'd5: rowBits = (seg[2] ? 8'b0100_0000 : 8'b0) | (seg[4] ? 8'b0000_0100 : 8'b0);
		3'd6: rowBits = seg[3] ? 8'b0111_1100 : 8'b0;
		// bottom row stays blank as spacing
		default: rowBits = 8'b0;
	endcase
	return rowBits;
endfunction

endpackage

`default_nettype wire

// ==== luckScreen.f ====
+incdir+verif
logic/screenPkg.sv
logic/apbPkg.sv
logic/rasterScanner.sv
logic/digitLayer.sv
logic/layerMixer.sv
logic/apbLayerRegs.sv
logic/luckScreen.sv
verif/luckScreenTb.sv

// ==== verif/luckScreenTests.svh ====
task automatic testResetState();
	logic [31:0] data;
	logic err;
	checkFrame("after reset");
	for (int k = 0; k < NUM_LAYERS; k++) begin
		apbRead(regAddr(k, CTRL_OFFSET), data, err);
		checkEq({err, data}, 33'd0, "control register not clear after reset");
		apbRead(regAddr(k, POS_OFFSET), data, err);
		checkEq({err, data}, 33'd0, "position register not clear after reset");
	end
endtask

task automatic testReadBack();
	layerCfgT c;
	logic [31:0] data;
	logic err;
	for (int k = 0; k < NUM_LAYERS; k++) begin
		c = randomCfg(0, 0, 2048);
		c.enable = 1'($random(seed));
		setLayer(k, c);
		apbRead(regAddr(k, CTRL_OFFSET), data, err);
		checkEq({err, data}, {1'b0, ctrlWord(c)}, "control register read-back");
		apbRead(regAddr(k, POS_OFFSET), data, err);
		checkEq({err, data}, {1'b0, posWord(c)}, "position register read-back");
	end
endtask

task automatic testSingleLayer();
	layerCfgT c;
	clearLayers();
	c = '0;
	c.enable = 1'b1;
	c.digit = 4'd8;
	c.colour = 8'hE3;
	c.topLeftX = 11'd5;
	c.topLeftY = 11'd7;
	setLayer(2, c);
	checkFrame("single layer");
endtask

// all glyphs land in one small patch, layer 1 stays off
task automatic testOverlap();
	layerCfgT c;
	repeat (2) begin
		for (int k = 0; k < NUM_LAYERS; k++) begin
			c = randomCfg(8, 6, 6);
			c.enable = (k != 1);
			setLayer(k, c);
		end
		checkFrame("overlapping layers");
	end
endtask

task automatic testErrors();
	layerCfgT bad;
	logic [31:0] data;
	logic err;
	apbWrite(regAddr(NUM_LAYERS, CTRL_OFFSET), 32'h8000_0001, err);
	checkEq(err, 1'b1, "no pslverr on an unmapped address");
	apbWrite(8'h02, 32'h8000_0001, err);
	checkEq(err, 1'b1, "no pslverr on a misaligned address");
	bad = model[1];
	bad.digit = 4'(10 + $unsigned($random(seed)) % 6);
	apbWrite(regAddr(1, CTRL_OFFSET), ctrlWord(bad), err);
	checkEq(err, 1'b1, "no pslverr on a digit above nine");
	for (int k = 0; k < NUM_LAYERS; k++) begin
		apbRead(regAddr(k, CTRL_OFFSET), data, err);
		checkEq({err, data}, {1'b0, ctrlWord(model[k])}, "control changed by a bad write");
		apbRead(regAddr(k, POS_OFFSET), data, err);
		checkEq({err, data}, {1'b0, posWord(model[k])}, "position changed by a bad write");
	end
endtask

task automatic testEdgeAndMove();
	layerCfgT c;
	clearLayers();
	c = '0;
	c.enable = 1'b1;
	c.digit = 4'd8;
	c.colour = 8'h1C;
	// clipped at the right and bottom edges
	c.topLeftX = coordT'(H_ACTIVE - 3);
	c.topLeftY = coordT'(V_ACTIVE - 5);
	setLayer(3, c);
	checkFrame("glyph at the corner");
	c.topLeftX = coordT'(H_ACTIVE - 6);
	c.topLeftY = 11'd2;
	setLayer(3, c);
	checkFrame("glyph after a move");
endtask

// ==== verif/luckScreenTb.sv ====
`default_nettype none

module luckScreenTb;

import screenPkg::*;
import apbPkg::*;

localparam int NUM_LAYERS = 4;
localparam int H_ACTIVE = 32;
localparam int V_ACTIVE = 24;
localparam int PERIOD = 100;
localparam int NUM_TESTS = 6;
// three frames per test and some slack for the APB traffic
localparam int WATCHDOG_TIME = (NUM_TESTS * 3 * H_ACTIVE * V_ACTIVE + 2000) * PERIOD;

logic		clk;
logic		rstN;
apbReqT		apbReq;
apbRspT		apbRsp;
layerOutT	pixelOut;
integer		seed;

// expected layer settings
layerCfgT	model [NUM_LAYERS];

luckScreen #(.NUM_LAYERS(NUM_LAYERS), .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) luckScreen_i(
	.clk(clk),
	.rstN(rstN),
	.apbReq(apbReq),
	.apbRsp(apbRsp),
	.pixelOut(pixelOut)
);

initial begin
	clk = 1'b0;
	forever #(PERIOD / 2) clk = ~clk;
end

initial begin
	#(WATCHDOG_TIME);
	$display("simulation hung: the tests did not finish within %0d time units", WATCHDOG_TIME);
	$display("Something failed");
	$fatal(1, "watchdog expired");
end

task automatic checkEq(input logic [63:0] actual, input logic [63:0] expected, input string msg);
	if (actual !== expected) begin
		$display("error at time %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
		$display("Something failed");
		$fatal(1, "stopping at the first mismatch");
	end
endtask

task automatic apbTransfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
	@(negedge clk);
	apbReq.psel = 1'b1;
	apbReq.penable = 1'b0;
	apbReq.pwrite = write;
	apbReq.paddr = addr;
	apbReq.pwdata = wdata;
	@(negedge clk);
	apbReq.penable = 1'b1;
	// response is valid through the access cycle
	@(posedge clk);
	checkEq(apbRsp.pready, 1'b1, "pready low in an access cycle");
	rdata = apbRsp.prdata;
	err = apbRsp.pslverr;
	@(negedge clk);
	apbReq = '0;
endtask

task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
	logic [31:0] unused;
	apbTransfer(1'b1, addr, data, unused, err);
endtask

task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
	apbTransfer(1'b0, addr, 32'd0, data, err);
endtask

function automatic logic [7:0] regAddr(input int k, input logic [7:0] off);
	return 8'(k * LAYER_STRIDE + off);
endfunction

// enable 31, digit 19..16, colour 7..0
function automatic logic [31:0] ctrlWord(input layerCfgT c);
	return {c.enable, 11'd0, c.digit, 8'd0, c.colour};
endfunction

// x 26..16, y 10..0
function automatic logic [31:0] posWord(input layerCfgT c);
	return {5'd0, c.topLeftX, 5'd0, c.topLeftY};
endfunction

function automatic layerCfgT randomCfg(input int xBase, input int yBase, input int span);
	layerCfgT c;
	c.enable = 1'b1;
	c.digit = 4'($unsigned($random(seed)) % 10);
	c.colour = 8'($random(seed));
	c.topLeftX = coordT'(xBase + $unsigned($random(seed)) % span);
	c.topLeftY = coordT'(yBase + $unsigned($random(seed)) % span);
	return c;
endfunction

task automatic setLayer(input int k, input layerCfgT c);
	logic err;
	apbWrite(regAddr(k, CTRL_OFFSET), ctrlWord(c), err);
	checkEq(err, 1'b0, "pslverr on a legal control write");
	apbWrite(regAddr(k, POS_OFFSET), posWord(c), err);
	checkEq(err, 1'b0, "pslverr on a legal position write");
	model[k] = c;
endtask

task automatic clearLayers();
	for (int k = 0; k < NUM_LAYERS; k++) begin
		setLayer(k, '0);
	end
endtask

// predicted draw flag and colour where the lowest enabled layer wins
function automatic logic [8:0] expectPixel(input int x, input int y);
	logic [8:0] result;
	logic [7:0] pattern;
	int col;
	int row;
	result = '0;
	for (int k = 0; k < NUM_LAYERS; k++) begin
		col = x - int'(model[k].topLeftX);
		row = y - int'(model[k].topLeftY);
		if (!result[8] && model[k].enable && col >= 0 && col < int'(GLYPH_SIZE)
				&& row >= 0 && row < int'(GLYPH_SIZE)) begin
			pattern = glyphRow(model[k].digit, row[2:0]);
			if (pattern[7 - col]) begin
				result = {1'b1, model[k].colour};
			end
		end
	end
	return result;
endfunction

task automatic checkFrame(input string what);
	string msg;
	// let recent register writes reach the output stage
	repeat (4) @(negedge clk);
	while (!(pixelOut.valid && pixelOut.frameStart)) begin
		@(negedge clk);
	end
	for (int y = 0; y < V_ACTIVE; y++) begin
		for (int x = 0; x < H_ACTIVE; x++) begin
			msg = $sformatf("%s, pixel (%0d,%0d)", what, x, y);
			checkEq(pixelOut.valid, 1'b1, {msg, " not valid"});
			checkEq(pixelOut.frameStart, (x == 0 && y == 0), {msg, " frame start"});
			checkEq({pixelOut.x, pixelOut.y}, {coordT'(x), coordT'(y)}, {msg, " coordinates"});
			checkEq({pixelOut.draw, pixelOut.colour}, expectPixel(x, y), {msg, " draw and colour"});
			@(negedge clk);
		end
	end
endtask

`include "luckScreenTests.svh"

initial begin
	seed = 32'h137d;
	apbReq = '0;
	rstN = 1'b0;
	for (int k = 0; k < NUM_LAYERS; k++) begin
		model[k] = '0;
	end
	repeat (2) @(posedge clk);
	@(negedge clk);
	rstN = 1'b1;
	testResetState();
	testReadBack();
	testSingleLayer();
	testOverlap();
	testErrors();
	testEdgeAndMove();
	$display("Everything OK");
	$finish;
end

endmodule

`default_nettype wire
